// File: src/apple2_video_pkg.sv
`default_nettype none

package apple2_video_pkg;

	typedef enum logic [1:0] {
		SCREEN_GREEN = 2'd0,
		SCREEN_WHITE = 2'd1,
		SCREEN_COLOR = 2'd2
	} screen_type_t; // same coding as status[2:1]

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// indexed by the 4-bit window after rotation to phase 0
	localparam rgb_t ARTIFACT_PALETTE [16] = '{
		'{8'h00, 8'h00, 8'h00}, // black
		'{8'hE3, 8'h1E, 8'h60}, // magenta
		'{8'h60, 8'h4E, 8'hBD}, // dark blue
		'{8'hFF, 8'h44, 8'hFD}, // purple
		'{8'h00, 8'hA3, 8'h60}, // dark green
		'{8'h9C, 8'h9C, 8'h9C}, // grey
		'{8'h14, 8'hCF, 8'hFD}, // medium blue
		'{8'hD0, 8'hC3, 8'hFF}, // light blue
		'{8'h60, 8'h72, 8'h03}, // brown
		'{8'hFF, 8'h6A, 8'h3C}, // orange
		'{8'h9C, 8'h9C, 8'h9C}, // grey
		'{8'hFF, 8'hA0, 8'hD0}, // pink
		'{8'h14, 8'hF5, 8'h3C}, // green
		'{8'hD0, 8'hDD, 8'h8D}, // yellow
		'{8'h72, 8'hFF, 8'hD0}, // aqua
		'{8'hFF, 8'hFF, 8'hFF}  // white
	};

	localparam rgb_t MONO_GREEN = '{8'h00, 8'hFF, 8'h00}; // green phosphor
	localparam rgb_t MONO_WHITE = '{8'hFF, 8'hFF, 8'hFF};

endpackage

`default_nettype wire

// File: src/apple2_io_pkg.sv
`default_nettype none

package apple2_io_pkg;

	localparam logic [7:0] PS2_BREAK = 8'hF0;
	localparam logic [7:0] PS2_EXTEND = 8'hE0;

	// about 140 us at 14.3 MHz, longer than the slowest PS/2 bit
	localparam int PS2_IDLE_CYCLES = 2000;

	localparam int SPK_LEVEL_HIGH = 3; // in quarters of full scale
	localparam int SPK_LEVEL_LOW = 1;

	function automatic int spk_level(input int width, input int quarters);
		return (quarters << width) >> 2;
	endfunction

	// set 2 make codes to Apple ASCII, zero when unmapped
	localparam logic [7:0] SCANCODE_ASCII [256] = '{
		8'h1C: 8'h41, 8'h32: 8'h42, 8'h21: 8'h43, 8'h23: 8'h44,
		8'h24: 8'h45, 8'h2B: 8'h46, 8'h34: 8'h47, 8'h33: 8'h48,
		8'h43: 8'h49, 8'h3B: 8'h4A, 8'h42: 8'h4B, 8'h4B: 8'h4C,
		8'h3A: 8'h4D, 8'h31: 8'h4E, 8'h44: 8'h4F, 8'h4D: 8'h50,
		8'h15: 8'h51, 8'h2D: 8'h52, 8'h1B: 8'h53, 8'h2C: 8'h54,
		8'h3C: 8'h55, 8'h2A: 8'h56, 8'h1D: 8'h57, 8'h22: 8'h58,
		8'h35: 8'h59, 8'h1A: 8'h5A,
		8'h45: 8'h30, 8'h16: 8'h31, 8'h1E: 8'h32, 8'h26: 8'h33,
		8'h25: 8'h34, 8'h2E: 8'h35, 8'h36: 8'h36, 8'h3D: 8'h37,
		8'h3E: 8'h38, 8'h46: 8'h39,
		8'h29: 8'h20, 8'h5A: 8'h0D, 8'h66: 8'h08,
		default: 8'h00
	};

endpackage

`default_nettype wire

// File: src/apple2_reset_gen.sv
`timescale 1ns/1ps
`default_nettype none

module apple2_reset_gen #(
	parameter int POR_BITS = 22,
	parameter int FLASH_BITS = 22
) (
	input  logic clk_14m,
	input  logic rst,
	output logic sys_reset,
	output logic flash_clk
);

	logic                  por_active;
	logic [POR_BITS-1:0]   por_cnt;
	logic [FLASH_BITS-1:0] flash_cnt;

	assign sys_reset = rst | por_active; // follows rst at once, then stretched

	always_ff @(posedge clk_14m) begin
		if (rst) begin
			por_active <= 1'b1;
			por_cnt <= '0;
		end else if (por_active) begin
			por_cnt <= por_cnt + 1'b1;
			if (&por_cnt)
				por_active <= 1'b0; // 2^POR_BITS cycles done
		end
	end

	// blink clock for flashing characters
	always_ff @(posedge clk_14m) begin
		if (sys_reset) begin
			flash_cnt <= '0;
			flash_clk <= 1'b0;
		end else begin
			flash_cnt <= flash_cnt + 1'b1;
			if (&flash_cnt)
				flash_clk <= ~flash_clk;
		end
	end

endmodule

`default_nettype wire

// File: src/ps2_keyboard.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard (
	input  logic       clk_14m,
	input  logic       rst,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	input  logic       read,
	output logic [7:0] k
);

	import apple2_io_pkg::*;

	localparam int IDLE_W = $clog2(PS2_IDLE_CYCLES + 1);

	logic [1:0]        clk_sync;
	logic [1:0]        data_sync;
	logic              clk_prev;
	logic              fall;
	logic [10:0]       frame;
	logic [10:0]       frame_next;
	logic [3:0]        bit_cnt;
	logic [IDLE_W-1:0] idle_cnt;
	logic              frame_end;
	logic              frame_ok;
	logic [7:0]        code;
	logic [7:0]        ascii;
	logic              skip_next;

	assign fall = clk_prev & ~clk_sync[1];
	assign frame_next = {data_sync[1], frame[10:1]}; // lsb first
	assign frame_end = fall && (bit_cnt == 4'd10); // stop bit arriving now
	assign code = frame_next[8:1];
	// start 0, stop 1, odd parity over data and parity bit
	assign frame_ok = !frame_next[0] && frame_next[10] && (^frame_next[9:1]);
	assign ascii = SCANCODE_ASCII[code];

	always_ff @(posedge clk_14m) begin
		if (rst) begin
			clk_sync <= 2'b11; // lines idle high
			data_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev <= clk_sync[1];
		end
	end

	always_ff @(posedge clk_14m) begin
		if (fall)
			frame <= frame_next;
	end

	always_ff @(posedge clk_14m) begin
		if (rst) begin
			bit_cnt <= '0;
			idle_cnt <= '0;
			skip_next <= 1'b0;
			k <= '0;
		end else begin
			if (fall) begin
				idle_cnt <= '0;
				bit_cnt <= frame_end ? 4'd0 : bit_cnt + 4'd1;
			end else if (bit_cnt != 4'd0) begin
				// mid-frame with no clock, drop the partial frame
				if (idle_cnt == IDLE_W'(PS2_IDLE_CYCLES - 1)) begin
					bit_cnt <= '0;
					idle_cnt <= '0;
				end else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
			end

			if (read)
				k[7] <= 1'b0; // strobe acknowledged

			// a new key wins over the read pulse
			if (frame_end && frame_ok) begin
				if (code == PS2_BREAK || code == PS2_EXTEND)
					skip_next <= 1'b1;
				else if (skip_next)
					skip_next <= 1'b0; // byte after a prefix
				else if (ascii != 8'h00)
					k <= {1'b1, ascii[6:0]};
			end
		end
	end

endmodule

`default_nettype wire

// File: src/video_colorizer.sv
`timescale 1ns/1ps
`default_nettype none

module video_colorizer (
	input  logic                         clk_14m,
	input  logic                         rst,
	input  logic                         video,
	input  logic                         color_line,
	input  logic                         ld194,
	input  logic                         hbl,
	input  logic                         vbl,
	input  apple2_video_pkg::screen_type_t screen_type,
	output logic [7:0]                   vga_r,
	output logic [7:0]                   vga_g,
	output logic [7:0]                   vga_b
);

	import apple2_video_pkg::*;

	logic [3:0] window;
	logic [1:0] phase;
	rgb_t       pix_next;
	rgb_t       pix_q;

	function automatic logic [3:0] rotl4(input logic [3:0] w, input logic [1:0] n);
		logic [7:0] twice;
		twice = {w, w};
		return twice[7 - n -: 4];
	endfunction

	always_comb begin
		pix_next = '0;
		if (hbl || vbl) begin
			pix_next = '0; // blanking
		end else if (screen_type == SCREEN_COLOR && color_line) begin
			pix_next = ARTIFACT_PALETTE[rotl4(window, phase)];
		end else if (window[0]) begin
			case (screen_type)
				SCREEN_GREEN: pix_next = MONO_GREEN;
				SCREEN_WHITE: pix_next = MONO_WHITE;
				default:      pix_next = MONO_WHITE; // text lines in color mode
			endcase
		end
	end

	always_ff @(posedge clk_14m) begin
		window <= {window[2:0], video};
	end

	always_ff @(posedge clk_14m) begin
		if (rst) begin
			phase <= '0;
			pix_q <= '0;
		end else begin
			phase <= ld194 ? 2'd0 : phase + 2'd1; // aligned to the 194 load
			pix_q <= pix_next;
		end
	end

	assign vga_r = pix_q.r;
	assign vga_g = pix_q.g;
	assign vga_b = pix_q.b;

endmodule

`default_nettype wire

// File: src/speaker_dac.sv
`timescale 1ns/1ps
`default_nettype none

module speaker_dac #(
	parameter int DAC_WIDTH = 8
) (
	input  logic clk_14m,
	input  logic rst,
	input  logic speaker,
	output logic audio
);

	import apple2_io_pkg::*;

	localparam logic [DAC_WIDTH-1:0] LEVEL_HIGH =
		DAC_WIDTH'(spk_level(DAC_WIDTH, SPK_LEVEL_HIGH));
	localparam logic [DAC_WIDTH-1:0] LEVEL_LOW =
		DAC_WIDTH'(spk_level(DAC_WIDTH, SPK_LEVEL_LOW));

	logic [DAC_WIDTH-1:0] level;
	logic [DAC_WIDTH:0]   acc;

	assign level = speaker ? LEVEL_HIGH : LEVEL_LOW;

	always_ff @(posedge clk_14m) begin
		if (rst)
			acc <= '0;
		else
			acc <= {1'b0, acc[DAC_WIDTH-1:0]} + {1'b0, level}; // carry is dropped next cycle
	end

	assign audio = acc[DAC_WIDTH];

endmodule

`default_nettype wire

// File: src/apple2_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module apple2_io_top #(
	parameter int POR_BITS = 22,
	parameter int FLASH_BITS = 22,
	parameter int DAC_WIDTH = 8
) (
	input  logic                         clk_14m,
	input  logic                         rst,
	input  logic                         ps2_clk,
	input  logic                         ps2_data,
	input  logic                         read,
	input  logic                         video,
	input  logic                         color_line,
	input  logic                         ld194,
	input  logic                         hbl,
	input  logic                         vbl,
	input  apple2_video_pkg::screen_type_t screen_type,
	input  logic                         speaker,
	output logic                         sys_reset,
	output logic                         flash_clk,
	output logic [7:0]                   k,
	output logic [7:0]                   vga_r,
	output logic [7:0]                   vga_g,
	output logic [7:0]                   vga_b,
	output logic                         audio_l,
	output logic                         audio_r
);

	apple2_reset_gen #(
		.POR_BITS   (POR_BITS),
		.FLASH_BITS (FLASH_BITS)
	) reset_gen0 (
		.clk_14m   (clk_14m),
		.rst       (rst),
		.sys_reset (sys_reset),
		.flash_clk (flash_clk)
	);

	ps2_keyboard keyboard0 (
		.clk_14m  (clk_14m),
		.rst      (sys_reset),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.read     (read),
		.k        (k)
	);

	video_colorizer colorizer0 (
		.clk_14m     (clk_14m),
		.rst         (sys_reset),
		.video       (video),
		.color_line  (color_line),
		.ld194       (ld194),
		.hbl         (hbl),
		.vbl         (vbl),
		.screen_type (screen_type),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b)
	);

	speaker_dac #(
		.DAC_WIDTH (DAC_WIDTH)
	) dac0 (
		.clk_14m (clk_14m),
		.rst     (sys_reset),
		.speaker (speaker),
		.audio   (audio_l)
	);

	assign audio_r = audio_l; // mono speaker on both channels

endmodule

`default_nettype wire

// File: verif/apple2_io_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module apple2_io_assertions (
	input logic       clk_14m,
	input logic       rst,
	input logic       sys_reset,
	input logic       read,
	input logic [7:0] k,
	input logic       hbl,
	input logic       vbl,
	input logic [7:0] vga_r,
	input logic [7:0] vga_g,
	input logic [7:0] vga_b
);

	int unsigned fail_count = 0; // read by the testbench at the end

	// the stretcher must still hold reset in the cycle after rst
	reset_covers_rst: assert property (@(posedge clk_14m) rst |-> sys_reset ##1 sys_reset)
		else begin
			fail_count++;
			$error("sys_reset is not held during rst and the cycle after it");
		end

	blank_is_black: assert property (@(posedge clk_14m)
		(hbl || vbl) |=> (vga_r == 8'h00 && vga_g == 8'h00 && vga_b == 8'h00))
		else begin
			fail_count++;
			$error("rgb not black one cycle after blanking");
		end

	// a different new code may set the strobe again in the same cycle
	read_clears_strobe: assert property (@(posedge clk_14m)
		(read && !sys_reset) |=> (!k[7] || k[6:0] != $past(k[6:0])))
		else begin
			fail_count++;
			$error("k[7] still set one cycle after a read pulse");
		end

endmodule

bind apple2_io_top apple2_io_assertions chk0 (.*);

`default_nettype wire

// File: verif/apple2_io_tb.sv
`timescale 1ns/1ps
`default_nettype none

module apple2_io_tb;

	import apple2_video_pkg::*;
	import apple2_io_pkg::*;

	localparam int POR_BITS = 4;
	localparam int FLASH_BITS = 6;
	localparam int DAC_WIDTH = 8;
	localparam int HALF = 8; // clk_14m cycles per PS/2 clock half period
	localparam int N_KEYS = 10;
	localparam int FRAME_BUDGET = 2 * 11 * HALF + 8;
	localparam int RESET_BUDGET = 5 + 2**POR_BITS + 4 * 2**FLASH_BITS;
	localparam int KEY_BUDGET = 24 * (FRAME_BUDGET + 2) + PS2_IDLE_CYCLES + 64;
	localparam int VIDEO_BUDGET = 4 + 12 * 48 + 4;
	localparam int DAC_BUDGET = 2 * (256 + 2);
	localparam int CYCLE_LIMIT = RESET_BUDGET + KEY_BUDGET + VIDEO_BUDGET + DAC_BUDGET + 200;

	// scancodes the keyboard test draws from
	localparam logic [7:0] KEY_CODES [10] = '{
		8'h1C, 8'h32, 8'h1A, 8'h4D, 8'h45, 8'h16, 8'h46, 8'h29, 8'h5A, 8'h66
	};

	logic         clk_14m;
	logic         rst;
	logic         ps2_clk;
	logic         ps2_data;
	logic         read;
	logic         video;
	logic         color_line;
	logic         ld194;
	logic         hbl;
	logic         vbl;
	screen_type_t screen_type;
	logic         speaker;
	logic         sys_reset;
	logic         flash_clk;
	logic [7:0]   k;
	logic [7:0]   vga_r;
	logic [7:0]   vga_g;
	logic [7:0]   vga_b;
	logic         audio_l;
	logic         audio_r;

	int          errors = 0;
	int          cycle_cnt = 0;
	logic [7:0]  exp_k;
	logic [7:0]  last_code; // last byte of a good frame
	logic [3:0]  model_win;
	logic [1:0]  model_phase;
	int          exp_due [$];
	rgb_t        exp_rgb [$];

	apple2_io_top #(
		.POR_BITS   (POR_BITS),
		.FLASH_BITS (FLASH_BITS),
		.DAC_WIDTH  (DAC_WIDTH)
	) dut0 (.*);

	initial begin
		clk_14m = 1'b0;
		forever #2 clk_14m = ~clk_14m;
	end

	function automatic logic [7:0] ascii_ref(input logic [7:0] sc);
		case (sc)
			8'h1C: return 8'h41; // A
			8'h32: return 8'h42;
			8'h1A: return 8'h5A;
			8'h4D: return 8'h50;
			8'h45: return 8'h30; // digits
			8'h16: return 8'h31;
			8'h46: return 8'h39;
			8'h29: return 8'h20;
			8'h5A: return 8'h0D; // return
			8'h66: return 8'h08;
			default: return 8'h00;
		endcase
	endfunction

	function automatic logic [7:0] k_ref(input logic [7:0] cur, input logic [7:0] prev,
			input logic [7:0] sc, input logic good);
		logic [7:0] a;
		a = ascii_ref(sc);
		if (!good || sc == 8'hF0 || sc == 8'hE0 || prev == 8'hF0 || prev == 8'hE0 || a == 8'h00)
			return cur;
		return {1'b1, a[6:0]};
	endfunction

	function automatic rgb_t rgb_ref(input logic [3:0] w, input logic [1:0] p,
			input screen_type_t st, input logic cl, input logic hb, input logic vb);
		logic [7:0] dbl;
		logic [3:0] idx;
		dbl = {4'h0, w} << p;
		idx = dbl[3:0] | dbl[7:4]; // rotate left by the phase
		if (hb || vb)
			return '0;
		if (st == SCREEN_COLOR && cl)
			return ARTIFACT_PALETTE[idx];
		if (!w[0])
			return '0;
		return (st == SCREEN_GREEN) ? MONO_GREEN : MONO_WHITE;
	endfunction

	function automatic int dac_ref(input int quarters);
		return quarters * (1 << DAC_WIDTH) / 4;
	endfunction

	task automatic tick();
		@(posedge clk_14m);
		#1;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) tick();
	endtask

	task automatic check_k(input string what);
		if (k !== exp_k) begin
			errors++;
			$display("ERR %0t: k is %h after %s, expected %h", $time, k, what, exp_k);
		end
	endtask

	task automatic pulse_read();
		read = 1'b1;
		tick();
		read = 1'b0;
		exp_k[7] = 1'b0;
		check_k("read pulse");
	endtask

	// sends the first nbits of a frame, a full frame is 11 bits
	task automatic ps2_send(input logic [7:0] code, input logic bad_parity, input int nbits);
		logic [10:0] bits;
		bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
		for (int i = 0; i < nbits; i++) begin
			ps2_clk = 1'b1;
			ps2_data = bits[i];
			wait_cycles(HALF);
			ps2_clk = 1'b0;
			wait_cycles(i == 10 ? 4 : HALF); // k is due 4 cycles after the stop bit
		end
		if (nbits == 11) begin
			exp_k = k_ref(exp_k, last_code, code, !bad_parity);
			if (!bad_parity)
				last_code = code;
			check_k($sformatf("frame %h", code));
		end
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		wait_cycles(HALF);
	endtask

	task automatic check_reset();
		int   n;
		logic prev;
		n = 0;
		while (sys_reset && n < 100) begin
			tick();
			n++;
		end
		if (n != 2**POR_BITS) begin
			errors++;
			$display("ERR %0t: sys_reset held %0d cycles, expected %0d", $time, n, 2**POR_BITS);
		end
		if (flash_clk !== 1'b0) begin
			errors++;
			$display("ERR %0t: flash_clk is %b after reset, expected 0", $time, flash_clk);
		end
		for (int t = 0; t < 3; t++) begin
			prev = flash_clk;
			n = 0;
			while (flash_clk === prev && n < 200) begin
				tick();
				n++;
			end
			if (n != 2**FLASH_BITS) begin
				errors++;
				$display("ERR %0t: flash_clk toggled after %0d cycles, expected %0d",
					$time, n, 2**FLASH_BITS);
			end
		end
	endtask

	task automatic check_keyboard();
		exp_k = 8'h00;
		last_code = 8'h00;
		check_k("reset");
		for (int i = 0; i < N_KEYS; i++) begin
			ps2_send(KEY_CODES[$urandom % 10], 1'b0, 11);
			if ($urandom % 2)
				pulse_read();
		end
		pulse_read();
		ps2_send(8'hF0, 1'b0, 11); // key release
		ps2_send(KEY_CODES[$urandom % 10], 1'b0, 11);
		ps2_send(8'hE0, 1'b0, 11); // keypad enter
		ps2_send(8'h5A, 1'b0, 11);
		ps2_send(8'hE0, 1'b0, 11);
		ps2_send(8'hF0, 1'b0, 11);
		ps2_send(8'h1C, 1'b0, 11);
		ps2_send(8'h76, 1'b0, 11); // escape and F1 are unmapped
		ps2_send(8'h05, 1'b0, 11);
		ps2_send(KEY_CODES[$urandom % 10], 1'b1, 11);
		ps2_send(KEY_CODES[$urandom % 10], 1'b0, 5);
		wait_cycles(PS2_IDLE_CYCLES + 16);
		check_k("cut off frame");
		ps2_send(KEY_CODES[$urandom % 10], 1'b0, 11); // receiver must be back in sync
		pulse_read();
	endtask

	task automatic video_step(input logic blank_en, input logic check, input logic force_ld);
		video = $urandom % 2;
		ld194 = force_ld || ($urandom % 8 == 0);
		hbl = blank_en && ($urandom % 4 == 0);
		vbl = blank_en && ($urandom % 4 == 0);
		if (check) begin
			exp_due.push_back(cycle_cnt + 1);
			exp_rgb.push_back(rgb_ref(model_win, model_phase, screen_type, color_line, hbl, vbl));
		end
		model_win = {model_win[2:0], video};
		model_phase = ld194 ? 2'd0 : model_phase + 2'd1;
		tick();
	endtask

	task automatic check_video();
		for (int i = 0; i < 4; i++)
			video_step(1'b0, 1'b0, i == 0); // fill the window, align the phase
		for (int m = 0; m < 3; m++) begin
			for (int cl = 0; cl < 2; cl++) begin
				for (int b = 0; b < 2; b++) begin
					screen_type = screen_type_t'(m);
					color_line = cl[0];
					repeat (48) video_step(b[0], 1'b1, 1'b0);
				end
			end
		end
		hbl = 1'b0;
		vbl = 1'b0;
		ld194 = 1'b0;
		wait_cycles(2);
	endtask

	task automatic check_dac();
		int ones;
		int exp_ones;
		for (int s = 1; s >= 0; s--) begin
			speaker = (s == 1);
			wait_cycles(2);
			ones = 0;
			for (int i = 0; i < 256; i++) begin
				tick();
				ones += audio_l;
				if (audio_r !== audio_l) begin
					errors++;
					$display("ERR %0t: audio_r %b differs from audio_l %b", $time, audio_r, audio_l);
				end
			end
			exp_ones = dac_ref(s == 1 ? 3 : 1);
			if (ones < exp_ones - 1 || ones > exp_ones + 1) begin
				errors++;
				$display("ERR %0t: %0d ones for speaker %0d, expected %0d", $time, ones, s, exp_ones);
			end
		end
	endtask

	// video compare, one cycle after the stimulus
	always @(negedge clk_14m) begin
		rgb_t want;
		if (exp_due.size() > 0 && exp_due[0] == cycle_cnt) begin
			want = exp_rgb.pop_front();
			void'(exp_due.pop_front());
			if ({vga_r, vga_g, vga_b} !== want) begin
				errors++;
				$display("ERR %0t: rgb %h%h%h, expected %h", $time, vga_r, vga_g, vga_b, want);
			end
		end
	end

	always @(posedge clk_14m) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		int seed;
		seed = $urandom(32'h574bb554);
		rst = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		read = 1'b0;
		video = 1'b0;
		color_line = 1'b0;
		ld194 = 1'b0;
		hbl = 1'b0;
		vbl = 1'b0;
		screen_type = SCREEN_GREEN;
		speaker = 1'b0;
		wait_cycles(5);
		rst = 1'b0;
		check_reset();
		check_keyboard();
		check_video();
		check_dac();
		$display("%0d check errors, %0d assertion failures", errors, dut0.chk0.fail_count);
		if (errors == 0 && dut0.chk0.fail_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: apple2_io.f
src/apple2_video_pkg.sv
src/apple2_io_pkg.sv
src/apple2_reset_gen.sv
src/ps2_keyboard.sv
src/video_colorizer.sv
src/speaker_dac.sv
src/apple2_io_top.sv
verif/apple2_io_assertions.sv
verif/apple2_io_tb.sv

// File: Bender.yml
package:
  name: apple2_io

sources:
  - src/apple2_video_pkg.sv
  - src/apple2_io_pkg.sv
  - src/apple2_reset_gen.sv
  - src/ps2_keyboard.sv
  - src/video_colorizer.sv
  - src/speaker_dac.sv
  - src/apple2_io_top.sv
  - target: simulation
    files:
      - verif/apple2_io_assertions.sv
      - verif/apple2_io_tb.sv
